//--- rtl/md_bus_pkg.sv
// shared page constants, widths and the Z80 address views, used by all bus arbiter RTL by scoped name
package md_bus_pkg;

	// 68000 page is byte address bits 23..8
	typedef logic [15:0] page_t;

	localparam page_t IO_PAGE     = 16'hA100; // joypad and version registers
	localparam page_t FDC_PAGE    = 16'hA120; // floppy controller
	localparam page_t TIME_PAGE   = 16'hA130; // cartridge timing strobe
	localparam page_t BUSREQ_PAGE = 16'hA111; // Z80 bus request bit
	localparam page_t ZRESET_PAGE = 16'hA112; // Z80 reset bit

	// upper byte of the page for the Z80 area seen from the 68000
	localparam logic [7:0] ZAREA_PREFIX = 8'hA0;

	localparam int BANK_W = 9;

	// bank register selects the 32 KB slice of 68000 space for the window
	typedef logic [BANK_W-1:0] bank_t;

	// region view, 8 KB regions
	typedef struct packed {
		logic [2:0]  region;
		logic [12:0] offset;
	} zregion_t;

	// window view, upper 32 KB window
	typedef struct packed {
		logic        window;
		logic [14:0] offset;
	} zwindow_t;

	// one Z80 address, decoded by region or by window
	typedef union packed {
		zregion_t rgn;
		zwindow_t win;
	} zaddr_u;

	localparam logic [2:0] REGION_ZRAM0   = 3'd0; // 0x0000..0x1FFF
	localparam logic [2:0] REGION_ZRAM1   = 3'd1; // 0x2000..0x3FFF
	localparam logic [2:0] REGION_SOUND   = 3'd2; // FM chip
	localparam logic [2:0] REGION_BANKREG = 3'd3; // bank register, page 0x60 only
	localparam logic [2:0] REGION_WINDOW  = 3'd4; // regions 4..7

	// offset bits 12..8 inside the bank register region that select page 0x60
	localparam logic [4:0] BANKREG_SUB = 5'h00;

endpackage

//--- rtl/m68k_decode.sv
// 68000-side page decoder with DTACK timing and the Z80 bus request and reset control bits
module m68k_decode #(
	parameter int DTACK_DELAY = 2
) (
	input  logic               MCLK,
	input  logic               rst_n_i,
	input  md_bus_pkg::page_t  vpage_i,
	input  logic               vas_n_i,
	input  logic               vrw_i,
	input  logic               vuds_n_i,
	input  logic               vd8_i,
	output logic               io_n_o,
	output logic               fdc_n_o,
	output logic               time_n_o,
	output logic               vdtack_n_o,
	output logic               zbus_req_o,
	output logic               zres_n_o,
	output logic               zarea_hit_o
);

	localparam int CNT_W = $clog2(DTACK_DELAY + 1);

	logic             io_pg, fdc_pg, time_pg;
	logic             busreq_pg, zreset_pg, zarea_pg;
	logic             dec_hit;
	logic             ctrl_wr;
	logic             io_n_q, fdc_n_q, time_n_q;
	logic             zarea_q;
	logic             dtack_n_q;
	logic [CNT_W-1:0] cnt_q;
	logic             zbr_q, zres_n_q;

	assign io_pg     = (vpage_i == md_bus_pkg::IO_PAGE);
	assign fdc_pg    = (vpage_i == md_bus_pkg::FDC_PAGE);
	assign time_pg   = (vpage_i == md_bus_pkg::TIME_PAGE);
	assign busreq_pg = (vpage_i == md_bus_pkg::BUSREQ_PAGE);
	assign zreset_pg = (vpage_i == md_bus_pkg::ZRESET_PAGE);
	assign zarea_pg  = (vpage_i[15:8] == md_bus_pkg::ZAREA_PREFIX);

	// Z80 area only answers while the 68000 holds the Z80 bus
	assign dec_hit = io_pg | fdc_pg | time_pg | busreq_pg | zreset_pg | (zarea_pg & zbr_q);

	assign ctrl_wr = ~vas_n_i & ~vrw_i & ~vuds_n_i;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			io_n_q   <= 1'b1;
			fdc_n_q  <= 1'b1;
			time_n_q <= 1'b1;
			zarea_q  <= 1'b0;
		end
		else
		begin
			io_n_q   <= vas_n_i | ~io_pg;
			fdc_n_q  <= vas_n_i | ~fdc_pg;
			time_n_q <= vas_n_i | ~time_pg;
			zarea_q  <= ~vas_n_i & zarea_pg;
		end
	end

	// counts strobe cycles until DTACK and holds it once reached
	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			cnt_q     <= '0;
			dtack_n_q <= 1'b1;
		end
		else if (vas_n_i)
		begin
			cnt_q     <= '0;
			dtack_n_q <= 1'b1;
		end
		else if (dec_hit && dtack_n_q)
		begin
			cnt_q <= cnt_q + CNT_W'(1);
			if (cnt_q == CNT_W'(DTACK_DELAY - 1))
				dtack_n_q <= 1'b0;
		end
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			zbr_q    <= 1'b0;
			zres_n_q <= 1'b0; // Z80 held in reset
		end
		else if (ctrl_wr)
		begin
			if (busreq_pg)
				zbr_q <= vd8_i;
			if (zreset_pg)
				zres_n_q <= vd8_i;
		end
	end

	assign io_n_o      = io_n_q;
	assign fdc_n_o     = fdc_n_q;
	assign time_n_o    = time_n_q;
	assign vdtack_n_o  = dtack_n_q;
	assign zbus_req_o  = zbr_q;
	assign zres_n_o    = zres_n_q;
	assign zarea_hit_o = zarea_q;

endmodule

//--- rtl/z80_decode.sv
// Z80-side region decoder with registered hit flags and the serially loaded bank register
module z80_decode (
	input  logic               MCLK,
	input  logic               rst_n_i,
	input  md_bus_pkg::zaddr_u za_i,
	input  logic               zmreq_n_i,
	input  logic               zwr_n_i,
	input  logic               zd0_i,
	output logic               zram_hit_o,
	output logic               sound_hit_o,
	output logic               win_hit_o,
	output md_bus_pkg::bank_t  bank_o
);

	logic              zram_rgn, sound_rgn, win_rgn, bank_rgn;
	logic              bank_wr, bank_wr_q;
	logic              zram_q, sound_q, win_q;
	md_bus_pkg::bank_t bank_q;

	assign zram_rgn  = (za_i.rgn.region == md_bus_pkg::REGION_ZRAM0) |
		(za_i.rgn.region == md_bus_pkg::REGION_ZRAM1);
	assign sound_rgn = (za_i.rgn.region == md_bus_pkg::REGION_SOUND);
	assign win_rgn   = (za_i.rgn.region >= md_bus_pkg::REGION_WINDOW);
	assign bank_rgn  = (za_i.rgn.region == md_bus_pkg::REGION_BANKREG) &
		(za_i.rgn.offset[12:8] == md_bus_pkg::BANKREG_SUB);

	assign bank_wr = ~zmreq_n_i & ~zwr_n_i & bank_rgn;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			zram_q    <= 1'b0;
			sound_q   <= 1'b0;
			win_q     <= 1'b0;
			bank_wr_q <= 1'b0;
		end
		else
		begin
			zram_q    <= ~zmreq_n_i & zram_rgn;
			sound_q   <= ~zmreq_n_i & sound_rgn;
			win_q     <= ~zmreq_n_i & win_rgn;
			bank_wr_q <= bank_wr;
		end
	end

	// one shift per write, new bit enters at the top
	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			bank_q <= '0;
		else if (bank_wr && !bank_wr_q)
			bank_q <= {zd0_i, bank_q[md_bus_pkg::BANK_W-1:1]};
	end

	assign zram_hit_o  = zram_q;
	assign sound_hit_o = sound_q;
	assign win_hit_o   = win_q;
	assign bank_o      = bank_q;

endmodule

//--- rtl/bank_bridge.sv
// joins the two decoders, gates Z80 selects by bus ownership and runs the banked window access
module bank_bridge (
	input  logic               MCLK,
	input  logic               rst_n_i,
	input  md_bus_pkg::zaddr_u za_i,
	input  logic               zram_hit_i,
	input  logic               sound_hit_i,
	input  logic               win_hit_i,
	input  logic               zbus_req_i,
	input  logic               zres_n_i,
	input  logic               zarea_hit_i,
	input  md_bus_pkg::bank_t  bank_i,
	input  logic               vdtack_n_i,
	input  logic               zmreq_n_i,
	output md_bus_pkg::page_t  va_o,
	output logic               vas_n_o,
	output logic               zwait_n_o,
	output logic               zram_n_o,
	output logic               sound_n_o
);

	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_STROBE  = 2'd1;
	localparam logic [1:0] ST_RELEASE = 2'd2;

	logic              z80_off;
	logic [1:0]        state_q;
	logic              vas_n_q;
	md_bus_pkg::page_t va_q;

	// 68000 owns the Z80 bus or keeps the Z80 in reset
	assign z80_off = zbus_req_i | ~zres_n_i;

	assign zram_n_o  = z80_off ? ~zarea_hit_i : ~zram_hit_i;
	assign sound_n_o = z80_off | ~sound_hit_i;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= ST_IDLE;
			vas_n_q <= 1'b1;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
				begin
					if (win_hit_i && !z80_off)
					begin
						vas_n_q <= 1'b0;
						state_q <= ST_STROBE;
					end
				end
				ST_STROBE:
				begin
					if (!vdtack_n_i)
					begin
						vas_n_q <= 1'b1;
						state_q <= ST_RELEASE;
					end
				end
				ST_RELEASE:
				begin
					if (zmreq_n_i)
						state_q <= ST_IDLE; // Z80 cycle ended
				end
				default:
				begin
					vas_n_q <= 1'b1;
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// address held for the whole strobe
	always_ff @(posedge MCLK)
	begin
		if (state_q == ST_IDLE && win_hit_i && !z80_off)
			va_q <= {bank_i, za_i.win.offset[14:8]};
	end

	assign va_o      = va_q;
	assign vas_n_o   = vas_n_q;
	assign zwait_n_o = vas_n_q; // Z80 stalls while the strobe is out

endmodule

//--- rtl/md_bus_arbiter.sv
// top level of the two-CPU bus arbiter, instantiates the decoders and the window bridge
module md_bus_arbiter #(
	parameter int DTACK_DELAY = 2
) (
	input  logic               MCLK,
	input  logic               rst_n_i,
	input  md_bus_pkg::page_t  vpage_i,
	input  logic               vas_n_i,
	input  logic               vrw_i,
	input  logic               vuds_n_i,
	input  logic               vd8_i,
	input  md_bus_pkg::zaddr_u za_i,
	input  logic               zmreq_n_i,
	input  logic               zwr_n_i,
	input  logic               zd0_i,
	input  logic               vdtack_n_i,
	output logic               io_n_o,
	output logic               fdc_n_o,
	output logic               time_n_o,
	output logic               vdtack_n_o,
	output md_bus_pkg::page_t  va_o,
	output logic               vas_n_o,
	output logic               zwait_n_o,
	output logic               zram_n_o,
	output logic               sound_n_o,
	output logic               zbr_o,
	output logic               zres_n_o
);

	logic              zbus_req, zres_n, zarea_hit;
	logic              zram_hit, sound_hit, win_hit;
	md_bus_pkg::bank_t bank;

	m68k_decode #(
		.DTACK_DELAY(DTACK_DELAY)
	) m68k_decode_i (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.vpage_i(vpage_i),
		.vas_n_i(vas_n_i),
		.vrw_i(vrw_i),
		.vuds_n_i(vuds_n_i),
		.vd8_i(vd8_i),
		.io_n_o(io_n_o),
		.fdc_n_o(fdc_n_o),
		.time_n_o(time_n_o),
		.vdtack_n_o(vdtack_n_o),
		.zbus_req_o(zbus_req),
		.zres_n_o(zres_n),
		.zarea_hit_o(zarea_hit)
	);

	z80_decode z80_decode_i (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.za_i(za_i),
		.zmreq_n_i(zmreq_n_i),
		.zwr_n_i(zwr_n_i),
		.zd0_i(zd0_i),
		.zram_hit_o(zram_hit),
		.sound_hit_o(sound_hit),
		.win_hit_o(win_hit),
		.bank_o(bank)
	);

	bank_bridge bank_bridge_i (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.za_i(za_i),
		.zram_hit_i(zram_hit),
		.sound_hit_i(sound_hit),
		.win_hit_i(win_hit),
		.zbus_req_i(zbus_req),
		.zres_n_i(zres_n),
		.zarea_hit_i(zarea_hit),
		.bank_i(bank),
		.vdtack_n_i(vdtack_n_i),
		.zmreq_n_i(zmreq_n_i),
		.va_o(va_o),
		.vas_n_o(vas_n_o),
		.zwait_n_o(zwait_n_o),
		.zram_n_o(zram_n_o),
		.sound_n_o(sound_n_o)
	);

	assign zbr_o    = zbus_req;
	assign zres_n_o = zres_n;

endmodule

//--- bench/tb_checks.svh
// typed compare tasks, error counters and bounded wait loops, included by the bus arbiter testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int TIMEOUT = 200; // cycles allowed for any wait

int err_cnt = 0;
int tmo_cnt = 0;

task automatic check_bit(input string name, input logic got, input logic want);
	if (got !== want)
	begin
		err_cnt = err_cnt + 1;
		$display("FAILED at %0d ns: %s = %b, expected %b", $time, name, got, want);
	end
endtask

task automatic check_page(input string name, input md_bus_pkg::page_t got,
	input md_bus_pkg::page_t want);
	if (got !== want)
	begin
		err_cnt = err_cnt + 1;
		$display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, want);
	end
endtask

task automatic check_bank(input string name, input md_bus_pkg::bank_t got,
	input md_bus_pkg::bank_t want);
	if (got !== want)
	begin
		err_cnt = err_cnt + 1;
		$display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, want);
	end
endtask

task automatic report_timeout(input string what);
	tmo_cnt = tmo_cnt + 1;
	$display("Timeout at %0d ns: %s", $time, what);
endtask

task automatic cycles(input int n);
	int k;
	for (k = 0; k < n; k = k + 1)
		@(posedge MCLK);
endtask

// steps until vas_n_o reaches level, the expected level holds from edge number settle on
task automatic wait_strobe(input logic level, input int settle, input string what);
	int n;
	n = 0;
	while (vas_n_o !== level && n < TIMEOUT)
	begin
		@(posedge MCLK);
		n = n + 1;
		if (n >= settle)
			exp_vas_n = level;
		@(negedge MCLK);
	end
	if (vas_n_o !== level)
		report_timeout(what);
endtask

`endif

//--- bench/tb_md_bus_arbiter.sv
// bus arbiter testbench that drives both CPU sides and checks selects, control bits and window
module tb_md_bus_arbiter;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DTACK_DELAY = 2;

	logic               MCLK = 1'b0;
	logic               rst_n_i;
	md_bus_pkg::page_t  vpage_i;
	logic               vas_n_i, vrw_i, vuds_n_i, vd8_i;
	md_bus_pkg::zaddr_u za_i;
	logic               zmreq_n_i, zwr_n_i, zd0_i, vdtack_n_i;
	logic               io_n_o, fdc_n_o, time_n_o, vdtack_n_o;
	md_bus_pkg::page_t  va_o;
	logic               vas_n_o, zwait_n_o, zram_n_o, sound_n_o, zbr_o, zres_n_o;
	md_bus_pkg::bank_t  va_bank;

	// expected outputs start at their reset values
	logic exp_io_n = 1'b1, exp_fdc_n = 1'b1, exp_time_n = 1'b1, exp_dtack_n = 1'b1;
	logic exp_zbr = 1'b0, exp_zres_n = 1'b0;
	logic exp_vas_n = 1'b1, exp_zram_n = 1'b1, exp_sound_n = 1'b1;
	md_bus_pkg::page_t exp_va = '0;
	md_bus_pkg::bank_t exp_bank = '0;

	int seed = 24;
	int i;
	int rnd;

	`include "tb_checks.svh"

	md_bus_arbiter #(
		.DTACK_DELAY(DTACK_DELAY)
	) dut_i (.*);

	assign va_bank = va_o[15:7]; // bank sits in the upper bits of the window address

	always
		#50 MCLK = ~MCLK;

	function automatic logic decoded_ref(input md_bus_pkg::page_t pg, input logic zbr);
		return pg == md_bus_pkg::IO_PAGE || pg == md_bus_pkg::FDC_PAGE ||
			pg == md_bus_pkg::TIME_PAGE || pg == md_bus_pkg::BUSREQ_PAGE ||
			pg == md_bus_pkg::ZRESET_PAGE || (pg[15:8] == md_bus_pkg::ZAREA_PREFIX && zbr);
	endfunction

	function automatic logic dtack_ref(input logic dec, input int n);
		return !(dec && n >= DTACK_DELAY);
	endfunction

	function automatic logic ctrl_ref(input logic old, input logic pg_hit, input logic rw,
		input logic uds_n, input logic d8);
		return (pg_hit && !rw && !uds_n) ? d8 : old;
	endfunction

	// Z80 RAM select belongs to the 68000 while it holds the bus or the reset
	function automatic logic zram_ref(input logic z_ram, input logic v_zarea, input logic zbr,
		input logic zres_n);
		return (zbr || !zres_n) ? !v_zarea : !z_ram;
	endfunction

	function automatic md_bus_pkg::bank_t bank_ref(input md_bus_pkg::bank_t b, input logic d0);
		return {d0, b[md_bus_pkg::BANK_W-1:1]};
	endfunction

	function automatic md_bus_pkg::page_t va_ref(input md_bus_pkg::bank_t b,
		input md_bus_pkg::zaddr_u a);
		return {b, a.win.offset[14:8]};
	endfunction

	function automatic md_bus_pkg::page_t pick_page(input int r);
		case (r[2:0])
			3'd0: return md_bus_pkg::IO_PAGE;
			3'd1: return md_bus_pkg::FDC_PAGE;
			3'd2: return md_bus_pkg::TIME_PAGE;
			3'd3: return md_bus_pkg::BUSREQ_PAGE;
			3'd4: return md_bus_pkg::ZRESET_PAGE;
			3'd5: return {md_bus_pkg::ZAREA_PREFIX, r[15:8]};
			default: return r[31:16];
		endcase
	endfunction

	task automatic expect_access(input md_bus_pkg::page_t pg, input logic rw, input logic uds_n,
		input logic d8, input logic dec, input int n);
		exp_io_n    = (pg != md_bus_pkg::IO_PAGE);
		exp_fdc_n   = (pg != md_bus_pkg::FDC_PAGE);
		exp_time_n  = (pg != md_bus_pkg::TIME_PAGE);
		exp_dtack_n = dtack_ref(dec, n);
		exp_zbr     = ctrl_ref(exp_zbr, pg == md_bus_pkg::BUSREQ_PAGE, rw, uds_n, d8);
		exp_zres_n  = ctrl_ref(exp_zres_n, pg == md_bus_pkg::ZRESET_PAGE, rw, uds_n, d8);
		exp_zram_n  = zram_ref(1'b0, pg[15:8] == md_bus_pkg::ZAREA_PREFIX, exp_zbr, exp_zres_n);
	endtask

	task automatic m68k_access(input md_bus_pkg::page_t pg, input logic rw, input logic uds_n,
		input logic d8);
		logic dec;
		int   n;
		dec = decoded_ref(pg, exp_zbr);
		@(posedge MCLK);
		vpage_i  <= pg;
		vas_n_i  <= 1'b0;
		vrw_i    <= rw;
		vuds_n_i <= uds_n;
		vd8_i    <= d8;
		n = 0;
		// decoded pages end on DTACK and others after a fixed hold
		while (n < TIMEOUT && !(dec ? vdtack_n_o === 1'b0 : n >= DTACK_DELAY + 2))
		begin
			@(posedge MCLK);
			n = n + 1;
			expect_access(pg, rw, uds_n, d8, dec, n);
			@(negedge MCLK);
		end
		if (n >= TIMEOUT)
			report_timeout("no DTACK for a decoded 68000 page");
		@(posedge MCLK);
		expect_access(pg, rw, uds_n, d8, dec, n + 1); // strobe still sampled low here
		vas_n_i  <= 1'b1;
		vuds_n_i <= 1'b1;
		vrw_i    <= 1'b1;
		@(posedge MCLK);
		exp_io_n    = 1'b1;
		exp_fdc_n   = 1'b1;
		exp_time_n  = 1'b1;
		exp_dtack_n = 1'b1;
		exp_zram_n  = 1'b1;
	endtask

	task automatic z80_read(input logic [15:0] addr, input int hold);
		int k;
		@(posedge MCLK);
		za_i      <= addr;
		zmreq_n_i <= 1'b0;
		zwr_n_i   <= 1'b1;
		for (k = 0; k < hold; k = k + 1)
		begin
			@(posedge MCLK);
			exp_zram_n = zram_ref(addr[15:13] == md_bus_pkg::REGION_ZRAM0 ||
				addr[15:13] == md_bus_pkg::REGION_ZRAM1, 1'b0, exp_zbr, exp_zres_n);
			exp_sound_n = exp_zbr || !exp_zres_n || addr[15:13] != md_bus_pkg::REGION_SOUND;
		end
		@(posedge MCLK);
		zmreq_n_i <= 1'b1;
		@(posedge MCLK);
		exp_zram_n  = 1'b1;
		exp_sound_n = 1'b1;
	endtask

	task automatic bank_write(input logic d0, input logic [7:0] lo, input int hold);
		@(posedge MCLK);
		za_i      <= {md_bus_pkg::REGION_BANKREG, md_bus_pkg::BANKREG_SUB, lo};
		zmreq_n_i <= 1'b0;
		zwr_n_i   <= 1'b0;
		zd0_i     <= d0;
		exp_bank = bank_ref(exp_bank, d0); // one shift however long the write lasts
		cycles(hold);
		@(posedge MCLK);
		zmreq_n_i <= 1'b1;
		zwr_n_i   <= 1'b1;
	endtask

	task automatic window_read(input logic [14:0] off, input int dly);
		md_bus_pkg::zaddr_u a;
		a = {1'b1, off};
		exp_va = va_ref(exp_bank, a);
		@(posedge MCLK);
		za_i      <= a;
		zmreq_n_i <= 1'b0;
		zwr_n_i   <= 1'b1;
		wait_strobe(1'b0, 2, "window strobe never fell"); // decode edge then strobe edge
		cycles(dly);
		@(posedge MCLK);
		vdtack_n_i <= 1'b0;
		wait_strobe(1'b1, 1, "window strobe never released");
		@(posedge MCLK);
		vdtack_n_i <= 1'b1;
		zmreq_n_i  <= 1'b1;
		cycles(2);
	endtask

	// compares every output in the middle of each cycle
	always @(negedge MCLK)
	begin
		check_bit("io_n_o", io_n_o, exp_io_n);
		check_bit("fdc_n_o", fdc_n_o, exp_fdc_n);
		check_bit("time_n_o", time_n_o, exp_time_n);
		check_bit("vdtack_n_o", vdtack_n_o, exp_dtack_n);
		check_bit("zbr_o", zbr_o, exp_zbr);
		check_bit("zres_n_o", zres_n_o, exp_zres_n);
		check_bit("vas_n_o", vas_n_o, exp_vas_n);
		check_bit("zwait_n_o", zwait_n_o, exp_vas_n); // Z80 stalls while the strobe is out
		check_bit("zram_n_o", zram_n_o, exp_zram_n);
		check_bit("sound_n_o", sound_n_o, exp_sound_n);
		if (!exp_vas_n)
		begin
			check_page("va_o", va_o, exp_va);
			check_bank("va_o bank", va_bank, exp_bank);
		end
	end

	initial
	begin
		rst_n_i    = 1'b0;
		vpage_i    = '0;
		vas_n_i    = 1'b1;
		vrw_i      = 1'b1;
		vuds_n_i   = 1'b1;
		vd8_i      = 1'b0;
		za_i       = '0;
		zmreq_n_i  = 1'b1;
		zwr_n_i    = 1'b1;
		zd0_i      = 1'b0;
		vdtack_n_i = 1'b1;
		cycles(16);
		rst_n_i <= 1'b1;
		cycles(2);
		for (i = 0; i < 40; i = i + 1)
		begin
			rnd = $random(seed);
			m68k_access(pick_page(rnd), 1'b1, rnd[20], rnd[21]);
		end
		// control writes with the upper data strobe sometimes left off
		for (i = 0; i < 8; i = i + 1)
		begin
			rnd = $random(seed);
			m68k_access(i[0] ? md_bus_pkg::ZRESET_PAGE : md_bus_pkg::BUSREQ_PAGE, 1'b0,
				rnd[0] & rnd[1], rnd[2]);
		end
		m68k_access(md_bus_pkg::BUSREQ_PAGE, 1'b0, 1'b0, 1'b0);
		m68k_access(md_bus_pkg::BUSREQ_PAGE, 1'b0, 1'b1, 1'b1); // bit stays clear without UDS
		m68k_access(md_bus_pkg::ZRESET_PAGE, 1'b0, 1'b0, 1'b1); // Z80 out of reset
		m68k_access(md_bus_pkg::ZRESET_PAGE, 1'b0, 1'b1, 1'b0); // stays out of reset without UDS
		rnd = $random(seed);
		z80_read({md_bus_pkg::REGION_ZRAM1, rnd[12:0]}, 3);
		z80_read({md_bus_pkg::REGION_SOUND, rnd[28:16]}, 3);
		for (i = 0; i < 9; i = i + 1)
		begin
			rnd = $random(seed);
			bank_write(rnd[0], rnd[15:8], 2 + 32'(rnd[5:4]));
		end
		for (i = 0; i < 4; i = i + 1)
		begin
			rnd = $random(seed);
			window_read(rnd[14:0], 32'(rnd[27:24]) % 11);
		end
		// 68000 takes the bus and shuts out Z80 RAM access
		m68k_access(md_bus_pkg::BUSREQ_PAGE, 1'b0, 1'b0, 1'b1);
		rnd = $random(seed);
		z80_read({md_bus_pkg::REGION_ZRAM0, rnd[12:0]}, 3);
		m68k_access({md_bus_pkg::ZAREA_PREFIX, rnd[23:16]}, 1'b1, 1'b0, 1'b0);
		cycles(2);
		$display("%0d value errors, %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- md_bus_arbiter.f
+incdir+bench
rtl/md_bus_pkg.sv
rtl/m68k_decode.sv
rtl/z80_decode.sv
rtl/bank_bridge.sv
rtl/md_bus_arbiter.sv
bench/tb_md_bus_arbiter.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_md_bus_arbiter
FILELIST  ?= md_bus_arbiter.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
